/* src/eth_pkg.sv */
package eth_pkg;

	// line symbols
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hd5;
	localparam int preamble_len = 7;

	// frame field sizes in bytes
	localparam int head_len = 14;
	localparam int min_payload = 46;
	localparam int fcs_len = 4;
	localparam int gap_len = 12;

	// reflected polynomial, register shifts right
	localparam logic [31:0] crc_poly = 32'hedb88320;
	// register value after data plus a good FCS
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	// sent msb first, dmac leads
	typedef struct packed {
		logic [47:0] dmac;
		logic [47:0] smac;
		logic [15:0] ethertype;
	} eth_head_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} tx_byte_t;

	typedef struct packed {
		logic [7:0] data;
		logic last;
	} rx_byte_t;

	typedef struct packed {
		logic crc_ok;
		logic phy_err;
		logic overflow;
		logic [15:0] length;
	} rx_status_t;

endpackage

/* src/crc32_d8.sv */
`timescale 1ns/1ps

module crc32_d8 (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic enable,
	input logic [7:0] data,
	output logic [31:0] crc,
	output logic residue_ok
);
	import eth_pkg::*;

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// one byte, lsb first
	always_comb begin
		crc_next = crc_q ^ {24'h000000, data};
		for (int i = 0; i < 8; i++) begin
			crc_next = crc_next[0] ? ((crc_next >> 1) ^ crc_poly) : (crc_next >> 1);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			crc_q <= '1;
		end else if (clear) begin
			crc_q <= '1;
		end else if (enable) begin
			crc_q <= crc_next;
		end
	end

	// byte 0 of the FCS sits in crc[7:0]
	assign crc = ~crc_q;
	assign residue_ok = (crc_q == crc_residue);

endmodule

/* src/byte_buffer.sv */
`timescale 1ns/1ps

module byte_buffer #(
	parameter int DEPTH = 64,
	parameter type payload_t = logic [8:0]
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic full,
	output logic empty
);
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	// fall-through read
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/gmii_tx.sv */
`timescale 1ns/1ps

module gmii_tx (
	input logic clk,
	input logic reset,
	input eth_pkg::eth_head_t head,
	input logic start,
	output logic idle,
	input eth_pkg::tx_byte_t byte_in,
	input logic byte_empty,
	output logic byte_pop,
	output logic [7:0] txd,
	output logic tx_en,
	output logic tx_er
);
	import eth_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_PRE, S_HEAD, S_PAY, S_PAD, S_FCS, S_GAP} state_t;

	state_t state_q;
	state_t state_d;
	logic [15:0] cnt_q;
	logic [15:0] cnt_d;
	eth_head_t head_q;
	logic underrun_q;
	logic [31:0] crc;
	logic [31:0] fcs_q;
	logic [7:0] line_byte;
	logic line_er;
	logic crc_en;
	logic accept;

	assign idle = (state_q == S_IDLE);
	assign accept = idle && start;

	crc32_d8 u_crc (
		.clk(clk),
		.reset(reset),
		.clear(accept),
		.enable(crc_en),
		.data(line_byte),
		.crc(crc),
		.residue_ok()
	);

	// line byte for the next edge
	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q + 1'b1;
		line_byte = 8'h00;
		line_er = 1'b0;
		byte_pop = 1'b0;
		crc_en = 1'b0;
		case (state_q)
			S_IDLE: begin
				cnt_d = '0;
				if (start) begin
					state_d = S_PRE;
				end
			end
			S_PRE: begin
				line_byte = (cnt_q == 16'(preamble_len)) ? sfd_byte : preamble_byte;
				if (cnt_q == 16'(preamble_len)) begin
					state_d = S_HEAD;
					cnt_d = '0;
				end
			end
			S_HEAD: begin
				line_byte = head_q[head_len*8-1 -: 8];
				crc_en = 1'b1;
				if (cnt_q == 16'(head_len - 1)) begin
					state_d = S_PAY;
					cnt_d = '0;
				end
			end
			S_PAY: begin
				crc_en = 1'b1;
				if (byte_empty) begin
					line_er = 1'b1;
				end else begin
					line_byte = byte_in.data;
					byte_pop = 1'b1;
				end
				// an underrun closes the payload early
				if (byte_empty || byte_in.last) begin
					if (cnt_q < 16'(min_payload - 1)) begin
						state_d = S_PAD;
					end else begin
						state_d = S_FCS;
						cnt_d = '0;
					end
				end
			end
			S_PAD: begin
				crc_en = 1'b1;
				line_er = underrun_q;
				if (cnt_q == 16'(min_payload - 1)) begin
					state_d = S_FCS;
					cnt_d = '0;
				end
			end
			S_FCS: begin
				line_byte = (cnt_q == '0) ? crc[7:0] : fcs_q[7:0];
				if (cnt_q == 16'(fcs_len - 1)) begin
					state_d = S_GAP;
					cnt_d = '0;
				end
			end
			default: begin
				// one extra cycle covers the output register lag
				if (cnt_q == 16'(gap_len)) begin
					state_d = S_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= S_IDLE;
			cnt_q <= '0;
			underrun_q <= 1'b0;
			txd <= 8'h00;
			tx_en <= 1'b0;
			tx_er <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
			if (accept) begin
				underrun_q <= 1'b0;
			end else if (state_q == S_PAY && byte_empty) begin
				underrun_q <= 1'b1;
			end
			txd <= line_byte;
			tx_en <= state_q inside {S_PRE, S_HEAD, S_PAY, S_PAD, S_FCS};
			tx_er <= line_er;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			head_q <= head;
		end else if (state_q == S_HEAD) begin
			head_q <= {head_q[head_len*8-9:0], 8'h00};
		end
		// latch the finished crc, then shift out
		if (state_q == S_FCS) begin
			fcs_q <= (cnt_q == '0) ? {8'h00, crc[31:8]} : {8'h00, fcs_q[31:8]};
		end
	end

endmodule

/* src/gmii_rx.sv */
`timescale 1ns/1ps

module gmii_rx (
	input logic clk,
	input logic reset,
	input logic [7:0] rxd,
	input logic rx_dv,
	input logic rx_er,
	output eth_pkg::eth_head_t head,
	output logic head_valid,
	output eth_pkg::rx_byte_t byte_out,
	output logic byte_push,
	input logic byte_full,
	output eth_pkg::rx_status_t status,
	output logic status_valid
);
	import eth_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_HUNT, S_HEAD, S_BODY, S_GAP} state_t;

	state_t state_q;
	state_t state_d;
	logic [7:0] rxd_q;
	logic dv_q;
	logic er_q;
	logic [3:0] cnt_q;
	logic [3:0][7:0] dl_q;
	logic [2:0] dl_cnt_q;
	logic [7:0] pend_q;
	logic pend_v_q;
	logic [15:0] len_q;
	logic ovf_q;
	logic err_q;
	logic sfd_seen;
	logic head_done;
	logic frame_end;
	logic dl_exit;
	logic crc_en;
	logic crc_ok;

	assign sfd_seen = dv_q && (rxd_q == sfd_byte) && (state_q inside {S_IDLE, S_HUNT});
	assign head_done = (state_q == S_HEAD) && dv_q && (cnt_q == 4'(head_len - 1));
	assign frame_end = (state_q == S_BODY) && !dv_q;
	// oldest byte leaves once four newer ones are held
	assign dl_exit = (state_q == S_BODY) && dv_q && (dl_cnt_q == 3'd4);
	assign crc_en = dv_q && (state_q inside {S_HEAD, S_BODY});

	// pending byte waits so the final one can carry last
	assign byte_push = pend_v_q && (dl_exit || frame_end);
	assign byte_out.data = pend_q;
	assign byte_out.last = frame_end;

	crc32_d8 u_crc (
		.clk(clk),
		.reset(reset),
		.clear(sfd_seen),
		.enable(crc_en),
		.data(rxd_q),
		.crc(),
		.residue_ok(crc_ok)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE, S_HUNT: begin
				if (!dv_q) begin
					state_d = S_IDLE;
				end else if (sfd_seen) begin
					state_d = S_HEAD;
				end else if (rxd_q == preamble_byte) begin
					state_d = S_HUNT;
				end else begin
					state_d = S_GAP;
				end
			end
			S_HEAD: begin
				if (!dv_q) begin
					state_d = S_IDLE;
				end else if (head_done) begin
					state_d = S_BODY;
				end
			end
			default: begin
				if (!dv_q) begin
					state_d = S_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxd_q <= 8'h00;
			dv_q <= 1'b0;
			er_q <= 1'b0;
			state_q <= S_IDLE;
			head_valid <= 1'b0;
			status_valid <= 1'b0;
			cnt_q <= '0;
			dl_cnt_q <= '0;
			pend_v_q <= 1'b0;
			len_q <= '0;
			ovf_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			rxd_q <= rxd;
			dv_q <= rx_dv;
			er_q <= rx_er;
			state_q <= state_d;
			head_valid <= head_done;
			status_valid <= frame_end;
			if (sfd_seen) begin
				cnt_q <= '0;
			end else if (state_q == S_HEAD && dv_q) begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (sfd_seen) begin
				dl_cnt_q <= '0;
				pend_v_q <= 1'b0;
				len_q <= '0;
			end else if (frame_end) begin
				pend_v_q <= 1'b0;
			end else if (dl_exit) begin
				pend_v_q <= 1'b1;
				len_q <= len_q + 1'b1;
			end else if (state_q == S_BODY && dv_q) begin
				dl_cnt_q <= dl_cnt_q + 1'b1;
			end
			if (sfd_seen) begin
				ovf_q <= 1'b0;
			end else if (byte_push && byte_full) begin
				ovf_q <= 1'b1;
			end
			if (state_q == S_IDLE) begin
				err_q <= dv_q && er_q;
			end else if (dv_q && er_q) begin
				err_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_HEAD && dv_q) begin
			head <= {head[head_len*8-9:0], rxd_q};
		end
		if (state_q == S_BODY && dv_q) begin
			dl_q <= {dl_q[2:0], rxd_q};
		end
		if (dl_exit) begin
			pend_q <= dl_q[3];
		end
		if (frame_end) begin
			status.crc_ok <= crc_ok;
			status.phy_err <= err_q;
			status.overflow <= ovf_q || (byte_push && byte_full);
			status.length <= len_q;
		end
	end

endmodule

/* src/eth_gmii_mac.sv */
`timescale 1ns/1ps

module eth_gmii_mac #(
	parameter int TX_DEPTH = 64,
	parameter int RX_DEPTH = 64
) (
	input logic clk,
	input logic reset,
	input eth_pkg::tx_byte_t tx_in,
	input logic tx_in_valid,
	output logic tx_in_ready,
	input eth_pkg::eth_head_t tx_head,
	input logic tx_start,
	output logic tx_idle,
	output logic [7:0] gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er,
	input logic [7:0] gmii_rxd,
	input logic gmii_rx_dv,
	input logic gmii_rx_er,
	output eth_pkg::eth_head_t rx_head,
	output logic rx_head_valid,
	output eth_pkg::rx_status_t rx_status,
	output logic rx_status_valid,
	output eth_pkg::rx_byte_t rx_out,
	output logic rx_out_valid,
	input logic rx_out_ready
);
	import eth_pkg::*;

	tx_byte_t tx_buf_byte;
	logic tx_full;
	logic tx_empty;
	logic tx_pop;
	rx_byte_t rx_line_byte;
	logic rx_push;
	logic rx_full;
	logic rx_empty;

	assign tx_in_ready = !tx_full;
	assign rx_out_valid = !rx_empty;

	byte_buffer #(.DEPTH(TX_DEPTH), .payload_t(tx_byte_t)) u_tx_buf (
		.clk(clk), .reset(reset),
		.push(tx_in_valid), .push_data(tx_in),
		.pop(tx_pop), .pop_data(tx_buf_byte),
		.full(tx_full), .empty(tx_empty)
	);

	gmii_tx u_tx (
		.clk(clk), .reset(reset),
		.head(tx_head), .start(tx_start), .idle(tx_idle),
		.byte_in(tx_buf_byte), .byte_empty(tx_empty), .byte_pop(tx_pop),
		.txd(gmii_txd), .tx_en(gmii_tx_en), .tx_er(gmii_tx_er)
	);

	// line side cannot stall, full drops bytes
	byte_buffer #(.DEPTH(RX_DEPTH), .payload_t(rx_byte_t)) u_rx_buf (
		.clk(clk), .reset(reset),
		.push(rx_push), .push_data(rx_line_byte),
		.pop(rx_out_ready), .pop_data(rx_out),
		.full(rx_full), .empty(rx_empty)
	);

	gmii_rx u_rx (
		.clk(clk), .reset(reset),
		.rxd(gmii_rxd), .rx_dv(gmii_rx_dv), .rx_er(gmii_rx_er),
		.head(rx_head), .head_valid(rx_head_valid),
		.byte_out(rx_line_byte), .byte_push(rx_push), .byte_full(rx_full),
		.status(rx_status), .status_valid(rx_status_valid)
	);

endmodule

/* dv/eth_mac_tb.sv */
`timescale 1ns/1ps

module eth_mac_tb;
	import eth_pkg::*;

	localparam int n_frames = 23;
	localparam int m_good = 0;
	localparam int m_ready = 1;
	localparam int m_flip = 2;
	localparam int m_er = 3;
	localparam int m_ovf = 4;

	logic clk;
	logic reset;
	tx_byte_t tx_in;
	logic tx_in_valid;
	logic tx_in_ready;
	eth_head_t tx_head;
	logic tx_start;
	logic tx_idle;
	logic [7:0] gmii_txd;
	logic gmii_tx_en;
	logic gmii_tx_er;
	logic [7:0] gmii_rxd;
	logic gmii_rx_dv;
	logic gmii_rx_er;
	eth_head_t rx_head;
	logic rx_head_valid;
	rx_status_t rx_status;
	logic rx_status_valid;
	rx_byte_t rx_out;
	logic rx_out_valid;
	logic rx_out_ready = 1'b1;

	// line byte positions for error injection count from 1
	logic [15:0] line_idx = '0;
	logic flip_en;
	logic [15:0] flip_pos;
	logic [7:0] flip_mask;
	logic er_en;
	logic [15:0] er_pos;
	int ready_mode;

	int cyc = 0;
	int tx_er_cnt = 0;
	int errors;
	int pass_cnt;
	int fail_cnt;
	int wd_cycles = 0;
	int len_plan [n_frames];
	int mode_plan [n_frames];

	logic [7:0] pay [$];
	logic [7:0] exp_line [$];
	logic [7:0] exp_pay [$];
	logic [7:0] line_q [$];
	eth_head_t head_q [$];
	rx_status_t stat_q [$];
	rx_byte_t rx_q [$];

	eth_gmii_mac #(.TX_DEPTH(128), .RX_DEPTH(64)) DUT (
		.clk(clk), .reset(reset),
		.tx_in(tx_in), .tx_in_valid(tx_in_valid), .tx_in_ready(tx_in_ready),
		.tx_head(tx_head), .tx_start(tx_start), .tx_idle(tx_idle),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.rx_head(rx_head), .rx_head_valid(rx_head_valid),
		.rx_status(rx_status), .rx_status_valid(rx_status_valid),
		.rx_out(rx_out), .rx_out_valid(rx_out_valid), .rx_out_ready(rx_out_ready)
	);

	// loopback with optional corruption
	assign gmii_rxd = gmii_txd ^ ((flip_en && line_idx == flip_pos) ? flip_mask : 8'h00);
	assign gmii_rx_dv = gmii_tx_en;
	assign gmii_rx_er = gmii_tx_er || (er_en && gmii_tx_en && line_idx == er_pos);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// transmit line monitor
	always @(negedge clk) begin
		cyc <= cyc + 1;
		if (gmii_tx_en) begin
			line_idx <= line_idx + 1'b1;
			line_q.push_back(gmii_txd);
			if (gmii_tx_er) begin
				tx_er_cnt <= tx_er_cnt + 1;
			end
		end else begin
			line_idx <= '0;
		end
	end

	// host ready for the coming edge decides which byte is taken
	always @(negedge clk) begin
		case (ready_mode)
			0: rx_out_ready = 1'b1;
			1: rx_out_ready = 1'b0;
			default: rx_out_ready = 1'($urandom);
		endcase
		if (!reset) begin
			if (rx_head_valid) begin
				head_q.push_back(rx_head);
			end
			if (rx_status_valid) begin
				stat_q.push_back(rx_status);
			end
			if (rx_out_valid && rx_out_ready) begin
				rx_q.push_back(rx_out);
			end
		end
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int b = 0; b < 8; b++) begin
			if (r[0] ^ d[b]) begin
				r = (r >> 1) ^ 32'hedb88320;
			end else begin
				r = r >> 1;
			end
		end
		return r;
	endfunction

	function automatic string mode_name(input int m);
		case (m)
			m_ready: return "random ready";
			m_flip: return "flipped byte";
			m_er: return "rx_er pulse";
			m_ovf: return "overflow";
			default: return "good";
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at time %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs0);
		if (errors == errs0) begin
			pass_cnt++;
			$display("%s: pass", name);
		end else begin
			fail_cnt++;
			$display("%s: fail", name);
		end
	endtask

	task automatic plan_frames();
		int p;
		for (int f = 0; f < 20; f++) begin
			mode_plan[f] = (f % 5 == 4) ? m_ready : m_good;
			len_plan[f] = (mode_plan[f] == m_ready) ? 1 + $urandom % 40 : 1 + $urandom % 120;
		end
		// edges of the length range
		len_plan[0] = 1;
		len_plan[1] = 46;
		len_plan[2] = 120;
		mode_plan[20] = m_flip;
		len_plan[20] = 1 + $urandom % 120;
		mode_plan[21] = m_er;
		len_plan[21] = 1 + $urandom % 120;
		mode_plan[22] = m_ovf;
		len_plan[22] = 100;
		// frame time plus payload push and drain
		wd_cycles = 2000;
		for (int f = 0; f < n_frames; f++) begin
			p = (len_plan[f] < 46) ? 46 : len_plan[f];
			wd_cycles += 1 + 8 + 14 + p + 4 + 12 + 2 * len_plan[f];
		end
	endtask

	// expected line bytes and received payload
	task automatic build_line(input eth_head_t head, input int n);
		logic [31:0] c;
		logic [7:0] b;
		int p;
		exp_line.delete();
		exp_pay.delete();
		p = (n < 46) ? 46 : n;
		for (int i = 0; i < 7; i++) begin
			exp_line.push_back(8'h55);
		end
		exp_line.push_back(8'hd5);
		c = 32'hffffffff;
		for (int i = 0; i < 14; i++) begin
			b = head[111 - 8 * i -: 8];
			exp_line.push_back(b);
			c = crc_byte(c, b);
		end
		for (int i = 0; i < p; i++) begin
			b = (i < n) ? pay[i] : 8'h00;
			exp_line.push_back(b);
			exp_pay.push_back(b);
			c = crc_byte(c, b);
		end
		c = ~c;
		for (int i = 0; i < 4; i++) begin
			exp_line.push_back(c[8 * i +: 8]);
		end
	endtask

	task automatic check_reset();
		int errs0;
		errs0 = errors;
		if (!tx_idle) begin
			report_mismatch("tx_idle low after reset");
		end
		if (gmii_tx_en || gmii_tx_er) begin
			report_mismatch("gmii_tx_en or gmii_tx_er high after reset");
		end
		if (rx_head_valid || rx_status_valid || rx_out_valid) begin
			report_mismatch("receive valid high after reset");
		end
		finish_test("reset values", errs0);
	endtask

	task automatic run_frame(input int f);
		int n;
		int p;
		int mode;
		int errs0;
		int t0;
		int er0;
		int wait_cnt;
		logic bad;
		eth_head_t head;
		rx_status_t st;
		n = len_plan[f];
		mode = mode_plan[f];
		p = (n < 46) ? 46 : n;
		errs0 = errors;
		head = {$urandom, $urandom, $urandom, 16'($urandom)};
		pay.delete();
		for (int i = 0; i < n; i++) begin
			pay.push_back(8'($urandom));
		end
		build_line(head, n);
		ready_mode = (mode == m_ready) ? 2 : (mode == m_ovf) ? 1 : 0;
		flip_en = (mode == m_flip);
		flip_pos = 16'(9 + $urandom % (14 + p + 4));
		flip_mask = 8'(1 + $urandom % 255);
		er_en = (mode == m_er);
		er_pos = 16'(9 + $urandom % (14 + p));

		for (int i = 0; i < n; i++) begin
			tx_in.data = pay[i];
			tx_in.last = (i == n - 1);
			tx_in_valid = 1'b1;
			while (!tx_in_ready) @(negedge clk);
			@(negedge clk);
		end
		tx_in_valid = 1'b0;

		while (!tx_idle) @(negedge clk);
		line_q.delete();
		head_q.delete();
		stat_q.delete();
		rx_q.delete();
		er0 = tx_er_cnt;
		tx_head = head;
		tx_start = 1'b1;
		@(negedge clk);
		tx_start = 1'b0;
		t0 = cyc;
		if (gmii_tx_en) begin
			report_mismatch($sformatf("frame %0d tx_en high on the accepting edge", f));
		end
		@(negedge clk);
		if (!gmii_tx_en) begin
			report_mismatch($sformatf("frame %0d tx_en low one cycle after accept", f));
		end
		while (!tx_idle) @(negedge clk);
		if (cyc - t0 != 39 + p) begin
			report_mismatch($sformatf("frame %0d idle after %0d cycles, expected %0d",
				f, cyc - t0, 39 + p));
		end

		if (line_q.size() != exp_line.size()) begin
			report_mismatch($sformatf("frame %0d line length %0d, expected %0d",
				f, line_q.size(), exp_line.size()));
		end else begin
			bad = 1'b0;
			for (int i = 0; i < exp_line.size(); i++) begin
				if (!bad && line_q[i] != exp_line[i]) begin
					report_mismatch($sformatf("frame %0d line byte %0d got %02h expected %02h",
						f, i, line_q[i], exp_line[i]));
					bad = 1'b1;
				end
			end
		end
		if (tx_er_cnt != er0) begin
			report_mismatch($sformatf("frame %0d gmii_tx_er raised", f));
		end

		wait_cnt = 0;
		while (stat_q.size() == 0 && wait_cnt < 100) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (mode == m_ovf) begin
			ready_mode = 0;
		end
		while (rx_out_valid) @(negedge clk);

		if (stat_q.size() == 0) begin
			$display("frame %0d: no receive status was reported", f);
			errors++;
		end else begin
			st = stat_q.pop_front();
			if (st.crc_ok != (mode != m_flip) || st.phy_err != (mode == m_er)
					|| st.overflow != (mode == m_ovf) || st.length != 16'(p)) begin
				report_mismatch($sformatf("frame %0d status crc %b err %b ovf %b len %0d",
					f, st.crc_ok, st.phy_err, st.overflow, st.length));
			end
		end
		if (mode != m_flip) begin
			if (head_q.size() != 1 || head_q[0] != head) begin
				report_mismatch($sformatf("frame %0d received header differs", f));
			end
		end
		if (mode != m_flip && mode != m_ovf) begin
			if (rx_q.size() != p) begin
				report_mismatch($sformatf("frame %0d received %0d bytes, expected %0d",
					f, rx_q.size(), p));
			end else begin
				bad = 1'b0;
				for (int i = 0; i < p; i++) begin
					if (!bad && (rx_q[i].data != exp_pay[i] || rx_q[i].last != (i == p - 1))) begin
						report_mismatch($sformatf("frame %0d rx byte %0d got %02h/%b expected %02h",
							f, i, rx_q[i].data, rx_q[i].last, exp_pay[i]));
						bad = 1'b1;
					end
				end
			end
		end
		flip_en = 1'b0;
		er_en = 1'b0;
		finish_test($sformatf("frame %0d %s n=%0d", f, mode_name(mode), n), errs0);
	endtask

	initial begin
		void'($urandom(32'h6bca_5862));
		reset = 1'b1;
		tx_in = '0;
		tx_in_valid = 1'b0;
		tx_head = '0;
		tx_start = 1'b0;
		flip_en = 1'b0;
		flip_pos = '0;
		flip_mask = '0;
		er_en = 1'b0;
		er_pos = '0;
		ready_mode = 0;
		errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		plan_frames();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_reset();
		for (int f = 0; f < n_frames; f++) begin
			run_frame(f);
		end
		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
src/eth_pkg.sv
src/crc32_d8.sv
src/byte_buffer.sv
src/gmii_tx.sv
src/gmii_rx.sv
src/eth_gmii_mac.sv
dv/eth_mac_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module eth_mac_tb -f sources.f -o eth_mac_sim \
	&& ./obj_dir/eth_mac_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0
